/* neuro_fix_pkg.sv */
// Number formats for the theta loop datapath
// Samples are signed Q3.14 in 18 bits, so values must stay within about +/-8.0
`default_nettype none

package neuro_fix_pkg;

    // ====================
    // Sample format
    // ====================

    // Word width and fraction bits of one sample
    localparam int SAMPLE_W = 18;
    localparam int FRAC     = 14;

    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // Full product of two samples, before the FRAC shift
    localparam int PROD_W = 2 * SAMPLE_W;

    typedef logic signed [PROD_W-1:0] prod_t;

    // ====================
    // DAC format
    // ====================

    // Offset binary code for the external converter
    localparam int DAC_W = 12;

    typedef logic [DAC_W-1:0] dac_t;

    // Phase coupling gain, 0.25
    localparam sample_t K_PHASE    = 18'sd4096;
    // Oscillator start amplitude, 0.5
    localparam sample_t THETA_INIT = 18'sd8192;
    // Leak of each cortical unit, one quarter of the error per update
    localparam int      LEAK_SHIFT = 2;

endpackage

`default_nettype wire

/* neuro_net_pkg.sv */
// Network level types of the theta loop
// Theta steps assume the Q3.14 sample format and a fixed update rate
`default_nettype none

package neuro_net_pkg;

    import neuro_fix_pkg::*;

    // ====================
    // Cortical pattern
    // ====================

    // Bit order: sensory gamma, sensory alpha, assoc gamma, assoc alpha,
    // motor gamma, motor alpha (bit 0 first)
    localparam int N_UNITS = 6;

    typedef logic [N_UNITS-1:0] pattern_t;

    // Octant of the theta cycle, 0..3 encoding and 4..7 retrieval
    typedef logic [2:0] theta_phase_t;

    // Brain state select, codes 5..7 unused
    typedef enum logic [2:0] {
        BS_NORMAL      = 3'd0,
        BS_MEDITATION  = 3'd1,
        BS_ANESTHESIA  = 3'd2,
        BS_PSYCHEDELIC = 3'd3,
        BS_FLOW        = 3'd4
    } brain_state_e;

    // ====================
    // CA3 memory
    // ====================

    typedef enum logic [1:0] {
        CA3_IDLE   = 2'd0,
        CA3_LEARN  = 2'd1,
        CA3_RECALL = 2'd2
    } ca3_mode_e;

    typedef logic signed [3:0] weight_t;

    localparam weight_t      WEIGHT_MAX   = 4'sd7;
    localparam theta_phase_t LEARN_PHASE  = 3'd1;
    localparam theta_phase_t RECALL_PHASE = 3'd5;

    // Theta rotation per update, indexed by brain state
    localparam int N_STATES = 5;

    localparam sample_t THETA_STEP [N_STATES] = '{
        18'sd1608,
        18'sd1286,
        18'sd965,
        18'sd1930,
        18'sd1447
    };

endpackage

`default_nettype wire

/* theta_bus_if.sv */
// Update tick and theta state shared by the loop blocks
// All signals are registered at the source and change only on clk
`default_nettype none

interface theta_bus_if
    import neuro_fix_pkg::*, neuro_net_pkg::*;
();

    // Single cycle update strobe
    logic         tick;

    // Quadrature theta point and its octant
    sample_t      theta_x;
    sample_t      theta_y;
    theta_phase_t theta_phase;

    modport timer (output tick);

    modport osc (input tick, output theta_x, theta_y, theta_phase);

    modport sink (input tick, theta_x, theta_y, theta_phase);

endinterface

`default_nettype wire

/* rate_config.sv */
// Update tick divider and brain state lookup of the theta step
// CLK_DIV must be 4 or more, state codes 5 to 7 select the normal step
`default_nettype none

module rate_config
    import neuro_fix_pkg::*, neuro_net_pkg::*;
#(
    parameter int CLK_DIV = 8
) (
    input  logic         clk,
    input  logic         arst_n,
    input  brain_state_e state_select,
    output sample_t      theta_step,
    theta_bus_if.timer   bus
);

    localparam int               CNT_W    = $clog2(CLK_DIV);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLK_DIV - 1);
    localparam logic [CNT_W-1:0] CNT_PRE  = CNT_W'(CLK_DIV - 2);

    logic [CNT_W-1:0] div_cnt;

    // ====================
    // Tick divider
    // ====================

    // Tick is registered one count early so it is high while div_cnt is CNT_LAST
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt  <= '0;
            bus.tick <= 1'b0;
        end else begin
            if (div_cnt == CNT_LAST) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
            bus.tick <= (div_cnt == CNT_PRE);
        end
    end

    // ====================
    // Step lookup
    // ====================

    // One cycle of latency from state_select
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            theta_step <= THETA_STEP[BS_NORMAL];
        end else if (int'(state_select) < N_STATES) begin
            theta_step <= THETA_STEP[state_select];
        end else begin
            theta_step <= THETA_STEP[BS_NORMAL];
        end
    end

endmodule

`default_nettype wire

/* theta_oscillator.sv */
// Quadrature theta oscillator with an eight phase octant output
// Symplectic update, the step must stay well below 1.0 for a stable orbit
`default_nettype none

module theta_oscillator
    import neuro_fix_pkg::*, neuro_net_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  sample_t theta_step,
    theta_bus_if.osc bus
);

    prod_t   step_y;
    prod_t   step_x;
    sample_t x_next;
    sample_t y_next;

    // Octant counted counterclockwise from the -y axis
    // A boundary point goes to the higher octant, except x = 0 with y > 0 stays at 3
    function automatic theta_phase_t octant_of(input sample_t x, input sample_t y);
        logic [SAMPLE_W-1:0] ax;
        logic [SAMPLE_W-1:0] ay;
        ax = x[SAMPLE_W-1] ? -x : x;
        ay = y[SAMPLE_W-1] ? -y : y;
        if (!x[SAMPLE_W-1]) begin
            // Right half plane, encoding side
            if (y[SAMPLE_W-1]) begin
                return (ay > ax) ? 3'd0 : 3'd1;
            end
            return (ay < ax) ? 3'd2 : 3'd3;
        end
        // Left half plane, retrieval side
        if (!y[SAMPLE_W-1] && (y != '0)) begin
            return (ay > ax) ? 3'd4 : 3'd5;
        end
        return (ay >= ax) ? 3'd7 : 3'd6;
    endfunction

    // x moves first, then y uses the new x
    always_comb begin
        step_y = theta_step * bus.theta_y;
        x_next = bus.theta_x - sample_t'(step_y >>> FRAC);
        step_x = theta_step * x_next;
        y_next = bus.theta_y + sample_t'(step_x >>> FRAC);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bus.theta_x     <= THETA_INIT;
            bus.theta_y     <= '0;
            bus.theta_phase <= octant_of(THETA_INIT, '0);
        end else if (bus.tick) begin
            bus.theta_x     <= x_next;
            bus.theta_y     <= y_next;
            // Phase follows the new point on the same edge
            bus.theta_phase <= octant_of(x_next, y_next);
        end
    end

endmodule

`default_nettype wire

/* cortical_units.sv */
// Six leaky cortical units driven by gated input and theta phase coupling
// Sensory input should stay within +/-1.0 to keep every unit inside a sample
`default_nettype none

module cortical_units
    import neuro_fix_pkg::*, neuro_net_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  sample_t  sensory_input,
    input  pattern_t phase_pattern,
    theta_bus_if.sink bus,
    output pattern_t cortical_pattern,
    output dac_t     dac_output
);

    // Two guard bits for the sum of input and coupling
    localparam int WIDE_W      = SAMPLE_W + 2;
    localparam int MOTOR_GAMMA = 4;

    sample_t                  gated_input;
    prod_t                    k_theta_x;
    prod_t                    k_theta_y;
    sample_t                  couple_x;
    sample_t                  couple_y;
    sample_t                  couple    [N_UNITS];
    logic signed [WIDE_W-1:0] target    [N_UNITS];
    logic signed [WIDE_W-1:0] diff      [N_UNITS];
    sample_t                  unit_next [N_UNITS];
    sample_t                  unit_q    [N_UNITS];

    // ====================
    // Unit update
    // ====================

    always_comb begin
        // Half gain in the retrieval octants 4..7
        gated_input = bus.theta_phase[2] ? (sensory_input >>> 1) : sensory_input;
        k_theta_x   = K_PHASE * bus.theta_x;
        k_theta_y   = K_PHASE * bus.theta_y;
        couple_x    = sample_t'(k_theta_x >>> FRAC);
        couple_y    = sample_t'(k_theta_y >>> FRAC);
        for (int i = 0; i < N_UNITS; i++) begin
            // Gamma units follow theta_x, alpha units theta_y
            couple[i] = (i % 2 == 0) ? couple_x : couple_y;
            // In phase adds the coupling, anti phase subtracts it
            target[i] = WIDE_W'(gated_input)
                      + (phase_pattern[i] ? WIDE_W'(couple[i]) : -WIDE_W'(couple[i]));
            diff[i]      = target[i] - WIDE_W'(unit_q[i]);
            unit_next[i] = sample_t'(WIDE_W'(unit_q[i]) + (diff[i] >>> LEAK_SHIFT));
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < N_UNITS; i++) begin
                unit_q[i] <= '0;
            end
        end else if (bus.tick) begin
            unit_q <= unit_next;
        end
    end

    // ====================
    // Outputs
    // ====================

    // Active when the unit is zero or positive
    always_comb begin
        for (int i = 0; i < N_UNITS; i++) begin
            cortical_pattern[i] = ~unit_q[i][SAMPLE_W-1];
        end
    end

    // Motor gamma as offset binary, top bits only
    assign dac_output = {~unit_q[MOTOR_GAMMA][SAMPLE_W-1],
                         unit_q[MOTOR_GAMMA][SAMPLE_W-2 -: DAC_W-1]};

endmodule

`default_nettype wire

/* ca3_phase_memory.sv */
// CA3 phase memory with Hebbian learning and phase pattern recall
// Learns only on LEARN_PHASE ticks and recalls only on RECALL_PHASE ticks
`default_nettype none

module ca3_phase_memory
    import neuro_net_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  pattern_t  cortical_pattern,
    theta_bus_if.sink bus,
    output pattern_t  phase_pattern,
    output ca3_mode_e ca3_mode
);

    // Five terms of at most 7 each
    localparam int SUM_W = 7;

    weight_t                 w_q        [N_UNITS][N_UNITS];
    weight_t                 w_next     [N_UNITS][N_UNITS];
    logic signed [SUM_W-1:0] recall_sum [N_UNITS];
    pattern_t                recall_bits;

    // ====================
    // Learn and recall
    // ====================

    // Diagonal entries are never touched and stay zero
    always_comb begin
        for (int i = 0; i < N_UNITS; i++) begin
            recall_sum[i] = '0;
            for (int j = 0; j < N_UNITS; j++) begin
                w_next[i][j] = w_q[i][j];
                if (i != j) begin
                    // Agreeing units strengthen, disagreeing units weaken
                    if (cortical_pattern[i] == cortical_pattern[j]) begin
                        if (w_q[i][j] < WEIGHT_MAX) begin
                            w_next[i][j] = w_q[i][j] + 4'sd1;
                        end
                    end else if (w_q[i][j] > -WEIGHT_MAX) begin
                        w_next[i][j] = w_q[i][j] - 4'sd1;
                    end
                    // Recall uses the weights held before the edge
                    recall_sum[i] = recall_sum[i]
                        + (cortical_pattern[j] ? SUM_W'(w_q[i][j]) : -SUM_W'(w_q[i][j]));
                end
            end
            recall_bits[i] = ~recall_sum[i][SUM_W-1];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < N_UNITS; i++) begin
                for (int j = 0; j < N_UNITS; j++) begin
                    w_q[i][j] <= '0;
                end
            end
            phase_pattern <= '0;
            ca3_mode      <= CA3_IDLE;
        end else if (bus.tick) begin
            // Mode holds until the next tick edge
            if (bus.theta_phase == LEARN_PHASE) begin
                w_q      <= w_next;
                ca3_mode <= CA3_LEARN;
            end else if (bus.theta_phase == RECALL_PHASE) begin
                phase_pattern <= recall_bits;
                ca3_mode      <= CA3_RECALL;
            end else begin
                ca3_mode <= CA3_IDLE;
            end
        end
    end

endmodule

`default_nettype wire

/* theta_loop_processor.sv */
// Closed theta loop from sensory input through cortex and CA3 back to cortex
// Loop outputs change one edge after each tick and then hold for CLK_DIV cycles
`default_nettype none

module theta_loop_processor
    import neuro_fix_pkg::*, neuro_net_pkg::*;
#(
    parameter int CLK_DIV = 8
) (
    input  logic         clk,
    input  logic         arst_n,
    input  sample_t      sensory_input,
    input  brain_state_e state_select,
    output sample_t      theta_x,
    output theta_phase_t theta_phase,
    output pattern_t     cortical_pattern,
    output pattern_t     phase_pattern,
    output ca3_mode_e    ca3_mode,
    output dac_t         dac_output
);

    sample_t theta_step;

    // Tick and theta state for all loop blocks
    theta_bus_if theta_bus ();

    rate_config #(
        .CLK_DIV (CLK_DIV)
    ) rate_config_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .state_select (state_select),
        .theta_step   (theta_step),
        .bus          (theta_bus.timer)
    );

    theta_oscillator theta_oscillator_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .theta_step (theta_step),
        .bus        (theta_bus.osc)
    );

    // Cortex sees the phase pattern held before each update edge
    cortical_units cortical_units_inst (
        .clk              (clk),
        .arst_n           (arst_n),
        .sensory_input    (sensory_input),
        .phase_pattern    (phase_pattern),
        .bus              (theta_bus.sink),
        .cortical_pattern (cortical_pattern),
        .dac_output       (dac_output)
    );

    ca3_phase_memory ca3_phase_memory_inst (
        .clk              (clk),
        .arst_n           (arst_n),
        .cortical_pattern (cortical_pattern),
        .bus              (theta_bus.sink),
        .phase_pattern    (phase_pattern),
        .ca3_mode         (ca3_mode)
    );

    assign theta_x     = theta_bus.theta_x;
    assign theta_phase = theta_bus.theta_phase;

endmodule

`default_nettype wire

/* tb_theta_loop_processor.sv */
// Self-checking testbench of the theta loop with a bit-exact reference model
// Outputs are sampled one clock after each update edge with CLK_DIV fixed at 8
`default_nettype none

module tb_theta_loop_processor
    import neuro_fix_pkg::*, neuro_net_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_DIV        = 8;
    localparam int UPDATE_TIMEOUT = 4 * CLK_DIV;
    localparam int MAX_CYCLES     = 20000;
    // Offset and shift that turn a unit into a 12 bit offset binary code
    localparam int DAC_OFFSET     = 1 << (SAMPLE_W - 1);
    localparam int DAC_DROP       = SAMPLE_W - DAC_W;

    logic         clk;
    logic         arst_n;
    sample_t      sensory_input;
    brain_state_e state_select;
    sample_t      theta_x;
    theta_phase_t theta_phase;
    pattern_t     cortical_pattern;
    pattern_t     phase_pattern;
    ca3_mode_e    ca3_mode;
    dac_t         dac_output;

    // ====================
    // Reference state
    // ====================

    int           m_x;
    int           m_y;
    theta_phase_t m_phase;
    int           m_unit [N_UNITS];
    int           m_w    [N_UNITS][N_UNITS];
    pattern_t     m_pp;
    ca3_mode_e    m_mode;

    // Inputs the DUT holds until the next update edge
    brain_state_e held_state;
    sample_t      held_input;

    int   edge_cnt;
    int   check_cnt;
    int   err_cnt;
    int   test_err;
    int   retr_cnt;
    int   learn_cnt;
    int   recall_cnt;
    logic done;
    logic timed_out;

    theta_loop_processor #(
        .CLK_DIV (CLK_DIV)
    ) theta_loop_processor_inst (
        .clk              (clk),
        .arst_n           (arst_n),
        .sensory_input    (sensory_input),
        .state_select     (state_select),
        .theta_x          (theta_x),
        .theta_phase      (theta_phase),
        .cortical_pattern (cortical_pattern),
        .phase_pattern    (phase_pattern),
        .ca3_mode         (ca3_mode),
        .dac_output       (dac_output)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // Theta step per brain state
    // Unused codes rotate like normal
    function automatic int step_of(input brain_state_e st);
        case (st)
            BS_NORMAL:      return 1608;
            BS_MEDITATION:  return 1286;
            BS_ANESTHESIA:  return 965;
            BS_PSYCHEDELIC: return 1930;
            BS_FLOW:        return 1447;
            default:        return 1608;
        endcase
    endfunction

    // Octant of the angle counted from -y
    // Boundary points go to the higher octant
    function automatic theta_phase_t octant_ref(input int x, input int y);
        int ax;
        int ay;
        ax = (x < 0) ? -x : x;
        ay = (y < 0) ? -y : y;
        if (x >= 0) begin
            // Encoding half keeps the +y axis at 3
            if (y < 0) begin
                return (ax < ay) ? 3'd0 : 3'd1;
            end
            return (ay < ax) ? 3'd2 : 3'd3;
        end
        if (y > 0) begin
            return (ax < ay) ? 3'd4 : 3'd5;
        end
        return (ay < ax) ? 3'd6 : 3'd7;
    endfunction

    function automatic void reset_model();
        m_x     = int'(THETA_INIT);
        m_y     = 0;
        m_phase = octant_ref(m_x, m_y);
        m_pp    = '0;
        m_mode  = CA3_IDLE;
        for (int i = 0; i < N_UNITS; i++) begin
            m_unit[i] = 0;
            for (int j = 0; j < N_UNITS; j++) begin
                m_w[i][j] = 0;
            end
        end
    endfunction

    // One tick of the whole loop
    // Every block reads the state from before the edge
    function automatic void model_update(input brain_state_e st, input sample_t s);
        int       step;
        int       nx;
        int       gated;
        int       c;
        int       target;
        int       acc;
        pattern_t cp;
        step = step_of(st);
        for (int i = 0; i < N_UNITS; i++) begin
            cp[i] = (m_unit[i] >= 0);
        end
        // Cortex with half input gain in the retrieval half
        gated = (m_phase < 3'd4) ? int'(s) : (int'(s) >>> 1);
        for (int i = 0; i < N_UNITS; i++) begin
            c         = (int'(K_PHASE) * ((i % 2 == 0) ? m_x : m_y)) >>> FRAC;
            target    = m_pp[i] ? (gated + c) : (gated - c);
            m_unit[i] = m_unit[i] + ((target - m_unit[i]) >>> LEAK_SHIFT);
        end
        // CA3 learn or recall slot
        if (m_phase == LEARN_PHASE) begin
            for (int i = 0; i < N_UNITS; i++) begin
                for (int j = 0; j < N_UNITS; j++) begin
                    if (i != j) begin
                        acc = m_w[i][j] + ((cp[i] == cp[j]) ? 1 : -1);
                        if (acc > int'(WEIGHT_MAX)) acc = int'(WEIGHT_MAX);
                        if (acc < -int'(WEIGHT_MAX)) acc = -int'(WEIGHT_MAX);
                        m_w[i][j] = acc;
                    end
                end
            end
            m_mode = CA3_LEARN;
        end else if (m_phase == RECALL_PHASE) begin
            for (int i = 0; i < N_UNITS; i++) begin
                acc = 0;
                for (int j = 0; j < N_UNITS; j++) begin
                    if (i != j) begin
                        acc += cp[j] ? m_w[i][j] : -m_w[i][j];
                    end
                end
                m_pp[i] = (acc >= 0);
            end
            m_mode = CA3_RECALL;
        end else begin
            m_mode = CA3_IDLE;
        end
        // Oscillator update where y uses the new x
        nx      = m_x - ((step * m_y) >>> FRAC);
        m_y     = m_y + ((step * nx) >>> FRAC);
        m_x     = nx;
        m_phase = octant_ref(m_x, m_y);
    endfunction

    // ====================
    // Compare tasks
    // ====================

    task automatic check_sample(input string name, input sample_t exp_v, input sample_t act_v);
        check_cnt++;
        if (act_v !== exp_v) begin
            err_cnt++;
            $display("Error: %s expected 0x%h, got 0x%h", name, exp_v, act_v);
        end
    endtask

    task automatic check_phase(input string name, input theta_phase_t exp_v,
                               input theta_phase_t act_v);
        check_cnt++;
        if (act_v !== exp_v) begin
            err_cnt++;
            $display("Error: %s expected 0x%h, got 0x%h", name, exp_v, act_v);
        end
    endtask

    task automatic check_pattern(input string name, input pattern_t exp_v, input pattern_t act_v);
        check_cnt++;
        if (act_v !== exp_v) begin
            err_cnt++;
            $display("Error: %s expected 0x%h, got 0x%h", name, exp_v, act_v);
        end
    endtask

    task automatic check_mode(input string name, input ca3_mode_e exp_v, input ca3_mode_e act_v);
        check_cnt++;
        if (act_v !== exp_v) begin
            err_cnt++;
            $display("Error: %s expected 0x%h, got 0x%h", name, exp_v, act_v);
        end
    endtask

    task automatic check_dac(input string name, input dac_t exp_v, input dac_t act_v);
        check_cnt++;
        if (act_v !== exp_v) begin
            err_cnt++;
            $display("Error: %s expected 0x%h, got 0x%h", name, exp_v, act_v);
        end
    endtask

    task automatic compare_outputs();
        pattern_t cp_ref;
        for (int i = 0; i < N_UNITS; i++) begin
            cp_ref[i] = (m_unit[i] >= 0);
        end
        check_sample("theta_x", sample_t'(m_x), theta_x);
        check_phase("theta_phase", m_phase, theta_phase);
        check_pattern("cortical_pattern", cp_ref, cortical_pattern);
        check_pattern("phase_pattern", m_pp, phase_pattern);
        check_mode("ca3_mode", m_mode, ca3_mode);
        check_dac("dac_output", dac_t'((m_unit[4] + DAC_OFFSET) >>> DAC_DROP), dac_output);
    endtask

    // ====================
    // Stimulus helpers
    // ====================

    task automatic step_clock();
        @(posedge clk);
        edge_cnt++;
    endtask

    // Update edges fall on every CLK_DIV-th edge after reset
    task automatic wait_update();
        int guard;
        guard = 0;
        if (timed_out) return;
        do begin
            step_clock();
            guard++;
        end while ((edge_cnt % CLK_DIV != 0) && (guard < UPDATE_TIMEOUT));
        if (edge_cnt % CLK_DIV != 0) begin
            $display("Timeout: no update edge within %0d clock cycles", UPDATE_TIMEOUT);
            timed_out = 1'b1;
        end
    endtask

    // Advance one tick, then drive the inputs for the next interval
    task automatic run_update(input brain_state_e st, input sample_t s);
        wait_update();
        if (m_phase[2]) retr_cnt++;
        if (m_phase == LEARN_PHASE) learn_cnt++;
        if (m_phase == RECALL_PHASE) recall_cnt++;
        model_update(held_state, held_input);
        state_select  <= st;
        sensory_input <= s;
        held_state = st;
        held_input = s;
    endtask

    function automatic sample_t random_sample();
        int r;
        r = int'($urandom_range(32768));
        return sample_t'(r - 16384);
    endfunction

    // Two edges let the compare of the last tick land inside the test
    task automatic finish_test(input int num, input string name);
        step_clock();
        step_clock();
        $display("Test %0d (%s) finished with %0d errors", num, name, err_cnt - test_err);
        test_err = err_cnt;
    endtask

    // ====================
    // Compare process
    // ====================

    initial begin : compare_loop
        int       cyc;
        pattern_t last_pp;
        cyc     = 0;
        last_pp = '0;
        while (!done && cyc < MAX_CYCLES) begin
            @(posedge clk);
            if (arst_n === 1'b1) cyc++;
            if (cyc > CLK_DIV && cyc % CLK_DIV == 1) begin
                compare_outputs();
                if (phase_pattern !== last_pp && m_mode != CA3_RECALL) begin
                    err_cnt++;
                    $display("phase_pattern changed after a tick that was not a recall tick");
                end
                last_pp = phase_pattern;
            end
        end
        if (!done) begin
            $display("Timeout: compare process ran past %0d cycles", MAX_CYCLES);
            timed_out = 1'b1;
        end
    end

    // ====================
    // Tests
    // ====================

    initial begin : stimulus
        void'($urandom(70));
        arst_n        = 1'b0;
        sensory_input = '0;
        state_select  = BS_NORMAL;
        held_state    = BS_NORMAL;
        held_input    = '0;
        done          = 1'b0;
        timed_out     = 1'b0;
        edge_cnt      = 0;
        check_cnt     = 0;
        err_cnt       = 0;
        test_err      = 0;
        retr_cnt      = 0;
        learn_cnt     = 0;
        recall_cnt    = 0;
        reset_model();
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;

        // Reset values hold until the first tick
        for (int k = 1; k < CLK_DIV; k++) begin
            step_clock();
            if (k == 1) begin
                check_sample("theta_x", 18'sd8192, theta_x);
                check_dac("dac_output", 12'h800, dac_output);
            end
            compare_outputs();
        end
        run_update(BS_NORMAL, '0);
        finish_test(1, "reset values");

        for (int s = 0; s < N_STATES; s++) begin
            for (int n = 0; n < 64; n++) begin
                run_update(brain_state_e'(s), '0);
            end
        end
        finish_test(2, "theta rotation per state");

        // Codes 5 to 7 and then a return to a defined state
        for (int s = 5; s < 8; s++) begin
            for (int n = 0; n < 16; n++) begin
                run_update(brain_state_e'(s), '0);
            end
        end
        for (int n = 0; n < 8; n++) begin
            run_update(BS_MEDITATION, '0);
        end
        finish_test(3, "unused state codes");

        retr_cnt = 0;
        for (int n = 0; n < 48; n++) begin
            run_update(BS_NORMAL, 18'sd16384);
        end
        for (int n = 0; n < 48; n++) begin
            run_update(BS_NORMAL, -18'sd12000);
        end
        for (int n = 0; n < 96; n++) begin
            run_update(BS_NORMAL, random_sample());
        end
        if (retr_cnt == 0) begin
            err_cnt++;
            $display("No tick fell in a retrieval octant during the cortical test");
        end
        finish_test(4, "cortical units");

        learn_cnt  = 0;
        recall_cnt = 0;
        for (int n = 0; n < 200; n++) begin
            run_update(brain_state_e'($urandom_range(N_STATES - 1)), random_sample());
        end
        if (learn_cnt == 0 || recall_cnt == 0) begin
            err_cnt++;
            $display("Learn or recall slot never reached in 200 updates");
        end
        finish_test(5, "learning and recall");

        done = 1'b1;
        $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (timed_out || err_cnt != 0) begin
            $display("Regression failed");
        end else begin
            $display("Regression passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
neuro_fix_pkg.sv
neuro_net_pkg.sv
theta_bus_if.sv
rate_config.sv
theta_oscillator.sv
cortical_units.sv
ca3_phase_memory.sv
theta_loop_processor.sv
tb_theta_loop_processor.sv

/* Bender.yml */
package:
  name: theta_loop_processor

sources:
  - neuro_fix_pkg.sv
  - neuro_net_pkg.sv
  - theta_bus_if.sv
  - rate_config.sv
  - theta_oscillator.sv
  - cortical_units.sv
  - ca3_phase_memory.sv
  - theta_loop_processor.sv
  - target: simulation
    files:
      - tb_theta_loop_processor.sv
